// File: rv_ex.f
+incdir+sim
source/rv_ex_pkg.sv
source/operand_forward.sv
source/alu.sv
source/store_align.sv
source/branch_comp.sv
source/ex_result_merge.sv
source/ex_stage.sv
sim/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f rv_ex.f --top-module ex_stage_tb \
    --Mdir obj_dir -o ex_stage_sim

./obj_dir/ex_stage_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim/ex_model.svh
/*
 * execute stage reference model
 * expected operand, ALU, branch, store lane, CSR and UART values
 */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// write-back bypass, x0 excluded
function automatic logic [31:0] forwarded_value(input logic wb_en, input logic [4:0] wb_addr,
        input logic [4:0] src_addr, input logic [31:0] reg_val, input logic [31:0] wb_val);
    if (wb_en && (src_addr != 5'd0) && (src_addr == wb_addr)) begin
        return wb_val;
    end
    return reg_val;
endfunction

function automatic logic [31:0] alu_result_of(input logic [3:0] op, input logic [31:0] a,
        input logic [31:0] b);
    logic [63:0] sign_ext;
    logic [31:0] res;
    sign_ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
        rv_ex_pkg::ALU_ADD:   res = a + b;
        rv_ex_pkg::ALU_SUB:   res = a - b;
        rv_ex_pkg::ALU_SLL:   res = a << b[4:0];
        // signed compare by flipping the sign bits
        rv_ex_pkg::ALU_SLT:   res = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        rv_ex_pkg::ALU_SLTU:  res = {31'd0, a < b};
        rv_ex_pkg::ALU_XOR:   res = a ^ b;
        rv_ex_pkg::ALU_SRL:   res = a >> b[4:0];
        rv_ex_pkg::ALU_SRA:   res = sign_ext[31:0];
        rv_ex_pkg::ALU_OR:    res = a | b;
        rv_ex_pkg::ALU_AND:   res = a & b;
        rv_ex_pkg::ALU_PASS2: res = b;
        default:              res = 32'd0;
    endcase
    return res;
endfunction

function automatic logic branch_taken(input logic en, input logic [2:0] f3,
        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] sa;
    logic [31:0] sb;
    logic        res;
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    case (f3)
        rv_ex_pkg::F3_BEQ:  res = (a == b);
        rv_ex_pkg::F3_BNE:  res = (a != b);
        rv_ex_pkg::F3_BLT:  res = (sa < sb);
        rv_ex_pkg::F3_BGE:  res = (sa >= sb);
        rv_ex_pkg::F3_BLTU: res = (a < b);
        rv_ex_pkg::F3_BGEU: res = (a >= b);
        default:            res = 1'b0;
    endcase
    return en && res;
endfunction

// returns {byte enables, lane data}
function automatic logic [35:0] store_lanes(input logic en, input logic [2:0] f3,
        input logic [1:0] ofs, input logic [31:0] data);
    logic [3:0]  be;
    logic [31:0] wd;
    be = 4'd0;
    wd = 32'd0;
    if (en && (f3 == rv_ex_pkg::F3_SB)) begin
        be[ofs] = 1'b1;
    end else if (en && (f3 == rv_ex_pkg::F3_SH) && !ofs[0]) begin
        be[ofs] = 1'b1;
        be[ofs + 2'd1] = 1'b1;
    end else if (en && (f3 == rv_ex_pkg::F3_SW) && (ofs == 2'd0)) begin
        be = 4'hf;
    end
    for (int lane = 0; lane < 4; lane++) begin
        if (be[lane]) begin
            wd[8*lane +: 8] = data[8*(lane - int'(ofs)) +: 8];
        end
    end
    return {be, wd};
endfunction

function automatic logic [31:0] csr_operand(input logic [2:0] f3, input logic [31:0] rs1,
        input logic [31:0] imm);
    if (f3 == rv_ex_pkg::F3_CSRRW) begin
        return rs1;
    end
    if (f3 == rv_ex_pkg::F3_CSRRWI) begin
        return imm;
    end
    return 32'd0;
endfunction

function automatic logic [1:0] uart_code(input logic [31:0] addr, input logic [1:0] code);
    if (addr inside {rv_ex_pkg::PERIPH_ADDR_0, rv_ex_pkg::PERIPH_ADDR_1,
                     rv_ex_pkg::PERIPH_ADDR_2, rv_ex_pkg::PERIPH_ADDR_3,
                     rv_ex_pkg::PERIPH_ADDR_4}) begin
        return code;
    end
    return 2'd0;
endfunction

`endif

// File: sim/ex_stage_tb.sv
/*
 * execute stage testbench
 * random instructions from an LCG, checked one cycle later against the model
 */
`timescale 1ns/10ps

module ex_stage_tb;

    `include "ex_model.svh"

    localparam int NUM_VECTORS  = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int TIMEOUT_NS   = (NUM_VECTORS + RESET_CYCLES + 10) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    rv_ex_pkg::word_t      reg1_data;
    rv_ex_pkg::word_t      reg2_data;
    rv_ex_pkg::reg_addr_t  reg1_addr;
    rv_ex_pkg::reg_addr_t  reg2_addr;
    rv_ex_pkg::reg_addr_t  rd_addr;
    rv_ex_pkg::word_t      pc;
    rv_ex_pkg::word_t      pc_plus4;
    rv_ex_pkg::word_t      imm;
    rv_ex_pkg::alu_op_t    alu_op;
    rv_ex_pkg::funct3_t    funct3;
    rv_ex_pkg::src_sel_t   src_sel;
    rv_ex_pkg::word_t      fwd_data;
    rv_ex_pkg::reg_addr_t  fwd_addr;
    logic                  fwd_wb_en;
    logic                  store_en;
    logic                  branch_en;
    rv_ex_pkg::jump_t      jump;
    logic [1:0]            wr_sel;
    logic                  wb_en;
    logic                  csr_we;
    rv_ex_pkg::uart_ctrl_t uart_ctrl;

    rv_ex_pkg::word_t      alu_result_q;
    rv_ex_pkg::word_t      mem_wdata_q;
    rv_ex_pkg::word_t      csr_data_q;
    rv_ex_pkg::word_t      pc_plus4_q;
    rv_ex_pkg::byte_en_t   dmem_we_q;
    rv_ex_pkg::reg_addr_t  rd_addr_q;
    logic [1:0]            wr_sel_q;
    logic                  wb_en_q;
    logic                  csr_we_q;
    rv_ex_pkg::uart_ctrl_t uart_ctrl_q;
    logic                  flush_q;

    // expected EX/MEM contents for the instruction in flight
    logic [31:0] exp_alu;
    logic [31:0] exp_wdata;
    logic [31:0] exp_csr;
    logic [31:0] exp_pc4;
    logic [3:0]  exp_be;
    logic [4:0]  exp_rd;
    logic [1:0]  exp_wr_sel;
    logic        exp_wb_en;
    logic        exp_csr_we;
    logic [1:0]  exp_uart;
    logic        exp_flush;

    logic [31:0] seed;
    int          errors;
    int          checks;

    ex_stage DUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .reg1_addr_i (reg1_addr),
        .reg2_addr_i (reg2_addr),
        .rd_addr_i   (rd_addr),
        .pc_i        (pc),
        .pc_plus4_i  (pc_plus4),
        .imm_i       (imm),
        .alu_op_i    (alu_op),
        .funct3_i    (funct3),
        .src_sel_i   (src_sel),
        .fwd_data_i  (fwd_data),
        .fwd_addr_i  (fwd_addr),
        .fwd_wb_en_i (fwd_wb_en),
        .store_en_i  (store_en),
        .branch_en_i (branch_en),
        .jump_i      (jump),
        .wr_sel_i    (wr_sel),
        .wb_en_i     (wb_en),
        .csr_we_i    (csr_we),
        .uart_ctrl_i (uart_ctrl),
        .alu_result_o(alu_result_q),
        .mem_wdata_o (mem_wdata_q),
        .csr_data_o  (csr_data_q),
        .pc_plus4_o  (pc_plus4_q),
        .dmem_we_o   (dmem_we_q),
        .rd_addr_o   (rd_addr_q),
        .wr_sel_o    (wr_sel_q),
        .wb_en_o     (wb_en_q),
        .csr_we_o    (csr_we_q),
        .uart_ctrl_o (uart_ctrl_q),
        .flush_o     (flush_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fold the high bits down, the low LCG bits repeat quickly
    task automatic draw_random(output logic [31:0] r);
        seed = lcg_step(seed);
        r = seed ^ (seed >> 15);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("[ERROR] %0t ns %s expected %h actual %h",
                         $time, name, expected, actual);
            end
    endtask

    task automatic compare_outputs();
        check_value("alu_result_o", exp_alu, alu_result_q);
        check_value("mem_wdata_o", exp_wdata, mem_wdata_q);
        check_value("csr_data_o", exp_csr, csr_data_q);
        check_value("pc_plus4_o", exp_pc4, pc_plus4_q);
        check_value("dmem_we_o", 32'(exp_be), 32'(dmem_we_q));
        check_value("rd_addr_o", 32'(exp_rd), 32'(rd_addr_q));
        check_value("wr_sel_o", 32'(exp_wr_sel), 32'(wr_sel_q));
        check_value("wb_en_o", 32'(exp_wb_en), 32'(wb_en_q));
        check_value("csr_we_o", 32'(exp_csr_we), 32'(csr_we_q));
        check_value("uart_ctrl_o", 32'(exp_uart), 32'(uart_ctrl_q));
        check_value("flush_o", 32'(exp_flush), 32'(flush_q));
    endtask

    task automatic drive_vector();
        logic [31:0] r;
        logic [1:0]  kind;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] alu_res;
        logic [35:0] lanes;
        logic        taken;
        draw_random(r);
        // 0 alu, 1 store, 2 branch, 3 csr
        kind      = r[1:0];
        reg1_addr = {3'd0, r[3:2]};
        reg2_addr = {3'd0, r[5:4]};
        fwd_addr  = {3'd0, r[7:6]};
        fwd_wb_en = r[8];
        src_sel   = r[10:9];
        alu_op    = r[14:11];
        funct3    = r[17:15];
        rd_addr   = r[22:18];
        wr_sel    = r[24:23];
        wb_en     = r[25];
        csr_we    = r[26];
        uart_ctrl = r[28:27];
        store_en  = (kind == 2'd1);
        branch_en = (kind == 2'd2);
        draw_random(reg1_data);
        draw_random(reg2_data);
        draw_random(fwd_data);
        draw_random(r);
        pc       = {r[31:2], 2'b00};
        pc_plus4 = pc + 32'd4;
        draw_random(imm);
        draw_random(r);
        if (store_en) begin
            funct3 = {1'b0, funct3[1:0]};
        end
        jump = (!store_en && r[2:0] == 3'd0) ? r[4:3] : 2'd0;
        if (branch_en && r[5]) begin
            reg2_data = reg1_data;
        end
        // steer roughly one address in eight onto a peripheral register
        if (r[9:7] == 3'd0) begin
            alu_op     = rv_ex_pkg::ALU_PASS2;
            src_sel[1] = 1'b1;
            case (r[12:10])
                3'd0:    imm = rv_ex_pkg::PERIPH_ADDR_0;
                3'd1:    imm = rv_ex_pkg::PERIPH_ADDR_1;
                3'd2:    imm = rv_ex_pkg::PERIPH_ADDR_2;
                3'd3:    imm = rv_ex_pkg::PERIPH_ADDR_3;
                default: imm = rv_ex_pkg::PERIPH_ADDR_4;
            endcase
        end

        rs1v    = forwarded_value(fwd_wb_en, fwd_addr, reg1_addr, reg1_data, fwd_data);
        rs2v    = forwarded_value(fwd_wb_en, fwd_addr, reg2_addr, reg2_data, fwd_data);
        alu_res = alu_result_of(alu_op, src_sel[0] ? pc : rs1v, src_sel[1] ? imm : rs2v);
        lanes   = store_lanes(store_en, funct3, alu_res[1:0], rs2v);
        taken   = branch_taken(branch_en, funct3, rs1v, rs2v);

        exp_alu    = alu_res;
        exp_be     = lanes[35:32];
        exp_wdata  = lanes[31:0];
        exp_csr    = csr_operand(funct3, rs1v, imm);
        exp_uart   = uart_code(alu_res, uart_ctrl);
        exp_flush  = taken || (jump != 2'd0);
        exp_pc4    = pc_plus4;
        exp_rd     = rd_addr;
        exp_wr_sel = wr_sel;
        exp_wb_en  = wb_en;
        exp_csr_we = csr_we;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        seed      = 32'h11a7_2844;
        errors    = 0;
        checks    = 0;
        reg1_data = '0;
        reg2_data = '0;
        reg1_addr = '0;
        reg2_addr = '0;
        rd_addr   = '0;
        pc        = '0;
        pc_plus4  = '0;
        imm       = '0;
        alu_op    = '0;
        funct3    = '0;
        src_sel   = '0;
        fwd_data  = '0;
        fwd_addr  = '0;
        fwd_wb_en = 1'b0;
        store_en  = 1'b0;
        branch_en = 1'b0;
        jump      = '0;
        wr_sel    = '0;
        wb_en     = 1'b0;
        csr_we    = 1'b0;
        uart_ctrl = '0;
        {exp_alu, exp_wdata, exp_csr, exp_pc4, exp_be, exp_rd} = '0;
        {exp_wr_sel, exp_wb_en, exp_csr_we, exp_uart, exp_flush} = '0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        // live inputs on the last reset edge, the register must still clear
        drive_vector();
        wb_en     = 1'b1;
        csr_we    = 1'b1;
        jump      = 2'd3;
        uart_ctrl = 2'd3;
        rd_addr   = 5'd31;
        {exp_alu, exp_wdata, exp_csr, exp_pc4, exp_be, exp_rd} = '0;
        {exp_wr_sel, exp_wb_en, exp_csr_we, exp_uart, exp_flush} = '0;
        @(negedge clk);
        compare_outputs();
        rst_n = 1'b1;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            drive_vector();
            @(negedge clk);
            compare_outputs();
        end

        $display("vectors: %0d, checks: %0d, errors: %0d", NUM_VECTORS, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stimulus did not complete within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: source/ex_stage.sv
/*
 * RV32I execute stage top
 * forwarding, ALU, store alignment and branch resolve into EX/MEM
 */
`timescale 1ns/10ps

module ex_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_ex_pkg::word_t      reg1_data_i,
    input  rv_ex_pkg::word_t      reg2_data_i,
    input  rv_ex_pkg::reg_addr_t  reg1_addr_i,
    input  rv_ex_pkg::reg_addr_t  reg2_addr_i,
    input  rv_ex_pkg::reg_addr_t  rd_addr_i,
    input  rv_ex_pkg::word_t      pc_i,
    input  rv_ex_pkg::word_t      pc_plus4_i,
    input  rv_ex_pkg::word_t      imm_i,
    input  rv_ex_pkg::alu_op_t    alu_op_i,
    input  rv_ex_pkg::funct3_t    funct3_i,
    input  rv_ex_pkg::src_sel_t   src_sel_i,
    input  rv_ex_pkg::word_t      fwd_data_i,
    input  rv_ex_pkg::reg_addr_t  fwd_addr_i,
    input  logic                  fwd_wb_en_i,
    input  logic                  store_en_i,
    input  logic                  branch_en_i,
    input  rv_ex_pkg::jump_t      jump_i,
    input  logic [1:0]            wr_sel_i,
    input  logic                  wb_en_i,
    input  logic                  csr_we_i,
    input  rv_ex_pkg::uart_ctrl_t uart_ctrl_i,
    output rv_ex_pkg::word_t      alu_result_o,
    output rv_ex_pkg::word_t      mem_wdata_o,
    output rv_ex_pkg::word_t      csr_data_o,
    output rv_ex_pkg::word_t      pc_plus4_o,
    output rv_ex_pkg::byte_en_t   dmem_we_o,
    output rv_ex_pkg::reg_addr_t  rd_addr_o,
    output logic [1:0]            wr_sel_o,
    output logic                  wb_en_o,
    output logic                  csr_we_o,
    output rv_ex_pkg::uart_ctrl_t uart_ctrl_o,
    output logic                  flush_o
);

    rv_ex_pkg::word_t    op1;
    rv_ex_pkg::word_t    op2;
    rv_ex_pkg::word_t    cmp_a;
    rv_ex_pkg::word_t    cmp_b;
    rv_ex_pkg::word_t    store_data;
    rv_ex_pkg::word_t    alu_result;
    rv_ex_pkg::word_t    store_wdata;
    rv_ex_pkg::byte_en_t byte_en;
    logic                taken;

    operand_forward u_fwd (
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .pc_i        (pc_i),
        .imm_i       (imm_i),
        .fwd_data_i  (fwd_data_i),
        .reg1_addr_i (reg1_addr_i),
        .reg2_addr_i (reg2_addr_i),
        .fwd_addr_i  (fwd_addr_i),
        .fwd_wb_en_i (fwd_wb_en_i),
        .src_sel_i   (src_sel_i),
        .op1_o       (op1),
        .op2_o       (op2),
        .cmp_a_o     (cmp_a),
        .cmp_b_o     (cmp_b),
        .store_data_o(store_data)
    );

    alu u_alu (
        .op1_i   (op1),
        .op2_i   (op2),
        .alu_op_i(alu_op_i),
        .result_o(alu_result)
    );

    // lane offset comes from the effective address
    store_align u_store (
        .store_en_i  (store_en_i),
        .funct3_i    (funct3_i),
        .addr_lo_i   (alu_result[1:0]),
        .store_data_i(store_data),
        .byte_en_o   (byte_en),
        .wdata_o     (store_wdata)
    );

    branch_comp u_branch (
        .branch_en_i(branch_en_i),
        .funct3_i   (funct3_i),
        .a_i        (cmp_a),
        .b_i        (cmp_b),
        .taken_o    (taken)
    );

    ex_result_merge u_merge (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .alu_result_i (alu_result),
        .rs1_fwd_i    (cmp_a),
        .imm_i        (imm_i),
        .pc_plus4_i   (pc_plus4_i),
        .store_wdata_i(store_wdata),
        .byte_en_i    (byte_en),
        .funct3_i     (funct3_i),
        .rd_addr_i    (rd_addr_i),
        .wr_sel_i     (wr_sel_i),
        .wb_en_i      (wb_en_i),
        .csr_we_i     (csr_we_i),
        .uart_ctrl_i  (uart_ctrl_i),
        .taken_i      (taken),
        .jump_i       (jump_i),
        .alu_result_o (alu_result_o),
        .mem_wdata_o  (mem_wdata_o),
        .csr_data_o   (csr_data_o),
        .pc_plus4_o   (pc_plus4_o),
        .dmem_we_o    (dmem_we_o),
        .rd_addr_o    (rd_addr_o),
        .wr_sel_o     (wr_sel_o),
        .wb_en_o      (wb_en_o),
        .csr_we_o     (csr_we_o),
        .uart_ctrl_o  (uart_ctrl_o),
        .flush_o      (flush_o)
    );

endmodule

// File: source/ex_result_merge.sv
/*
 * result merge and EX/MEM register
 * CSR operand, UART gating and flush, captured once per cycle
 */
`timescale 1ns/10ps

module ex_result_merge (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_ex_pkg::word_t      alu_result_i,
    input  rv_ex_pkg::word_t      rs1_fwd_i,
    input  rv_ex_pkg::word_t      imm_i,
    input  rv_ex_pkg::word_t      pc_plus4_i,
    input  rv_ex_pkg::word_t      store_wdata_i,
    input  rv_ex_pkg::byte_en_t   byte_en_i,
    input  rv_ex_pkg::funct3_t    funct3_i,
    input  rv_ex_pkg::reg_addr_t  rd_addr_i,
    input  logic [1:0]            wr_sel_i,
    input  logic                  wb_en_i,
    input  logic                  csr_we_i,
    input  rv_ex_pkg::uart_ctrl_t uart_ctrl_i,
    input  logic                  taken_i,
    input  rv_ex_pkg::jump_t      jump_i,
    output rv_ex_pkg::word_t      alu_result_o,
    output rv_ex_pkg::word_t      mem_wdata_o,
    output rv_ex_pkg::word_t      csr_data_o,
    output rv_ex_pkg::word_t      pc_plus4_o,
    output rv_ex_pkg::byte_en_t   dmem_we_o,
    output rv_ex_pkg::reg_addr_t  rd_addr_o,
    output logic [1:0]            wr_sel_o,
    output logic                  wb_en_o,
    output logic                  csr_we_o,
    output rv_ex_pkg::uart_ctrl_t uart_ctrl_o,
    output logic                  flush_o
);

    rv_ex_pkg::word_t      csr_data;
    rv_ex_pkg::uart_ctrl_t uart_ctrl;
    logic                  periph_hit;
    logic                  flush;

    assign csr_data = (funct3_i == rv_ex_pkg::F3_CSRRW)  ? rs1_fwd_i :
                      (funct3_i == rv_ex_pkg::F3_CSRRWI) ? imm_i     : '0;

    assign periph_hit = (alu_result_i == rv_ex_pkg::PERIPH_ADDR_0) ||
                        (alu_result_i == rv_ex_pkg::PERIPH_ADDR_1) ||
                        (alu_result_i == rv_ex_pkg::PERIPH_ADDR_2) ||
                        (alu_result_i == rv_ex_pkg::PERIPH_ADDR_3) ||
                        (alu_result_i == rv_ex_pkg::PERIPH_ADDR_4);

    // uart code only reaches the bus on a peripheral access
    assign uart_ctrl = periph_hit ? uart_ctrl_i : '0;
    assign flush     = taken_i || (jump_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_result_o <= '0;
            mem_wdata_o  <= '0;
            csr_data_o   <= '0;
            pc_plus4_o   <= '0;
            dmem_we_o    <= '0;
            rd_addr_o    <= '0;
            wr_sel_o     <= '0;
            wb_en_o      <= 1'b0;
            csr_we_o     <= 1'b0;
            uart_ctrl_o  <= '0;
            flush_o      <= 1'b0;
        end else begin
            alu_result_o <= alu_result_i;
            mem_wdata_o  <= store_wdata_i;
            csr_data_o   <= csr_data;
            pc_plus4_o   <= pc_plus4_i;
            dmem_we_o    <= byte_en_i;
            rd_addr_o    <= rd_addr_i;
            wr_sel_o     <= wr_sel_i;
            wb_en_o      <= wb_en_i;
            csr_we_o     <= csr_we_i;
            uart_ctrl_o  <= uart_ctrl;
            flush_o      <= flush;
        end
    end

    // a taken branch carries no store into the MEM stage
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        taken_i |=> (dmem_we_o == '0));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown({alu_result_o, mem_wdata_o, csr_data_o, pc_plus4_o, dmem_we_o,
                     rd_addr_o, wr_sel_o, wb_en_o, csr_we_o, uart_ctrl_o, flush_o}));

endmodule

// File: source/branch_comp.sv
/*
 * branch comparator
 * resolves the six conditional branches on forwarded operands
 */
`timescale 1ns/10ps

module branch_comp (
    input  logic               branch_en_i,
    input  rv_ex_pkg::funct3_t funct3_i,
    input  rv_ex_pkg::word_t   a_i,
    input  rv_ex_pkg::word_t   b_i,
    output logic               taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (funct3_i)
            rv_ex_pkg::F3_BEQ:  cond = eq;
            rv_ex_pkg::F3_BNE:  cond = !eq;
            rv_ex_pkg::F3_BLT:  cond = lt_s;
            rv_ex_pkg::F3_BGE:  cond = !lt_s;
            rv_ex_pkg::F3_BLTU: cond = lt_u;
            rv_ex_pkg::F3_BGEU: cond = !lt_u;
            // 010 and 011 are not branch encodings
            default:            cond = 1'b0;
        endcase
    end

    assign taken_o = branch_en_i && cond;

endmodule

// File: source/store_align.sv
/*
 * store alignment
 * byte-lane enables and lane-shifted write data for sb, sh and sw
 */
`timescale 1ns/10ps

module store_align (
    input  logic                store_en_i,
    input  rv_ex_pkg::funct3_t  funct3_i,
    input  logic [1:0]          addr_lo_i,
    input  rv_ex_pkg::word_t    store_data_i,
    output rv_ex_pkg::byte_en_t byte_en_o,
    output rv_ex_pkg::word_t    wdata_o
);

    logic [4:0] lane_shift;

    assign lane_shift = {addr_lo_i, 3'b000};

    always_comb begin
        byte_en_o = '0;
        wdata_o   = '0;
        if (store_en_i) begin
            case (funct3_i)
                rv_ex_pkg::F3_SB: begin
                    byte_en_o = 4'b0001 << addr_lo_i;
                    wdata_o   = {24'b0, store_data_i[7:0]} << lane_shift;
                end
                rv_ex_pkg::F3_SH: begin
                    // halfword only at offset 0 or 2
                    if (!addr_lo_i[0]) begin
                        byte_en_o = 4'b0011 << addr_lo_i;
                        wdata_o   = {16'b0, store_data_i[15:0]} << lane_shift;
                    end
                end
                rv_ex_pkg::F3_SW: begin
                    if (addr_lo_i == 2'b00) begin
                        byte_en_o = 4'b1111;
                        wdata_o   = store_data_i;
                    end
                end
                default: begin
                    byte_en_o = '0;
                end
            endcase
        end
    end

    // a non-store slot must never write memory
    always_comb begin
        if (!store_en_i) begin
            assert (byte_en_o == '0)
                else $error("store_align: lanes enabled without store_en_i");
        end
    end

endmodule

// File: source/alu.sv
/*
 * RV32I integer ALU
 */
`timescale 1ns/10ps

module alu (
    input  rv_ex_pkg::word_t   op1_i,
    input  rv_ex_pkg::word_t   op2_i,
    input  rv_ex_pkg::alu_op_t alu_op_i,
    output rv_ex_pkg::word_t   result_o
);

    logic [4:0] shamt;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            rv_ex_pkg::ALU_ADD: begin
                result_o = op1_i + op2_i;
            end
            rv_ex_pkg::ALU_SUB: begin
                result_o = op1_i - op2_i;
            end
            rv_ex_pkg::ALU_SLL: begin
                result_o = op1_i << shamt;
            end
            rv_ex_pkg::ALU_SLT: begin
                result_o = {31'b0, $signed(op1_i) < $signed(op2_i)};
            end
            rv_ex_pkg::ALU_SLTU: begin
                result_o = {31'b0, op1_i < op2_i};
            end
            rv_ex_pkg::ALU_XOR: begin
                result_o = op1_i ^ op2_i;
            end
            rv_ex_pkg::ALU_SRL: begin
                result_o = op1_i >> shamt;
            end
            rv_ex_pkg::ALU_SRA: begin
                // arithmetic shift keeps the sign bit
                result_o = $unsigned($signed(op1_i) >>> shamt);
            end
            rv_ex_pkg::ALU_OR: begin
                result_o = op1_i | op2_i;
            end
            rv_ex_pkg::ALU_AND: begin
                result_o = op1_i & op2_i;
            end
            rv_ex_pkg::ALU_PASS2: begin
                result_o = op2_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: source/operand_forward.sv
/*
 * operand forwarding
 * bypasses the write-back value and builds ALU, compare and store operands
 */
`timescale 1ns/10ps

module operand_forward (
    input  rv_ex_pkg::word_t     reg1_data_i,
    input  rv_ex_pkg::word_t     reg2_data_i,
    input  rv_ex_pkg::word_t     pc_i,
    input  rv_ex_pkg::word_t     imm_i,
    input  rv_ex_pkg::word_t     fwd_data_i,
    input  rv_ex_pkg::reg_addr_t reg1_addr_i,
    input  rv_ex_pkg::reg_addr_t reg2_addr_i,
    input  rv_ex_pkg::reg_addr_t fwd_addr_i,
    input  logic                 fwd_wb_en_i,
    input  rv_ex_pkg::src_sel_t  src_sel_i,
    output rv_ex_pkg::word_t     op1_o,
    output rv_ex_pkg::word_t     op2_o,
    output rv_ex_pkg::word_t     cmp_a_o,
    output rv_ex_pkg::word_t     cmp_b_o,
    output rv_ex_pkg::word_t     store_data_o
);

    logic             rs1_hit;
    logic             rs2_hit;
    rv_ex_pkg::word_t rs1_val;
    rv_ex_pkg::word_t rs2_val;

    // x0 is hardwired, never take a bypass for it
    function automatic logic fwd_match(input rv_ex_pkg::reg_addr_t src_addr);
        return fwd_wb_en_i && (fwd_addr_i == src_addr) && (src_addr != '0);
    endfunction

    assign rs1_hit = fwd_match(reg1_addr_i);
    assign rs2_hit = fwd_match(reg2_addr_i);

    assign rs1_val = rs1_hit ? fwd_data_i : reg1_data_i;
    assign rs2_val = rs2_hit ? fwd_data_i : reg2_data_i;

    // pc / immediate take priority over the bypassed register
    assign op1_o = src_sel_i[rv_ex_pkg::SRC_PC_BIT]  ? pc_i  : rs1_val;
    assign op2_o = src_sel_i[rv_ex_pkg::SRC_IMM_BIT] ? imm_i : rs2_val;

    assign cmp_a_o      = rs1_val;
    assign cmp_b_o      = rs2_val;
    assign store_data_o = rs2_val;

endmodule

// File: source/rv_ex_pkg.sv
/*
 * RV32I execute stage shared definitions
 * widths, ALU and funct3 codes, operand select bits, peripheral map
 */
package rv_ex_pkg;

    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [3:0]        alu_op_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [1:0]        src_sel_t;
    typedef logic [3:0]        byte_en_t;
    typedef logic [1:0]        uart_ctrl_t;
    typedef logic [1:0]        jump_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    localparam alu_op_t ALU_PASS2 = 4'd10;  // lui

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRWI = 3'b101;

    // bit positions inside src_sel_t
    localparam int SRC_PC_BIT  = 0;
    localparam int SRC_IMM_BIT = 1;

    // memory mapped peripheral registers
    localparam word_t PERIPH_ADDR_0 = 32'h8000_0000;
    localparam word_t PERIPH_ADDR_1 = 32'h8000_0004;
    localparam word_t PERIPH_ADDR_2 = 32'h8000_0008;
    localparam word_t PERIPH_ADDR_3 = 32'h8000_0010;
    localparam word_t PERIPH_ADDR_4 = 32'h8000_0014;

endpackage
